// ==== flist.f ====
rv_arch_pkg.sv
rv_flow_pkg.sv
flow_if.sv
flow_decode.sv
reg_file.sv
next_pc_mux.sv
pc_ctrl.sv
pc_unit_top.sv
pc_unit_checker.sv
tb_pc_unit.sv

// ==== flow_decode.sv ====
`timescale 1ns/1ns

module flow_decode import rv_arch_pkg::*, rv_flow_pkg::*; (
   input inst_t     inst,
   flow_if.decode   flow
);

   logic [6:0] opcode;
   logic       is_ebreak;
   imm_t       imm_b;
   imm_t       imm_j;
   imm_t       imm_i;

   assign opcode = inst[6:0];

   // only bit 20 set above the opcode
   assign is_ebreak = (inst[31:7] == 25'h000_2000);

   // B-type: imm[12|10:5] rs2 rs1 f3 imm[4:1|11]
   assign imm_b = {
      {51{inst[31]}},
      inst[31],
      inst[7],
      inst[30:25],
      inst[11:8],
      1'b0
   };

   // J-type: imm[20|10:1|11|19:12]
   assign imm_j = {
      {43{inst[31]}},
      inst[31],
      inst[19:12],
      inst[20],
      inst[30:21],
      1'b0
   };

   assign imm_i = {{52{inst[31]}}, inst[31:20]};

   assign flow.cond = inst[14:12];
   assign flow.rs1  = inst[19:15];
   assign flow.rs2  = inst[24:20];

   always_comb begin
      flow.kind = flow_seq;
      flow.imm  = '0;
      case (opcode)
         op_branch: begin
            flow.kind = flow_branch;
            flow.imm  = imm_b;
         end
         op_jal: begin
            flow.kind = flow_jal;
            flow.imm  = imm_j;
         end
         op_jalr: begin
            flow.kind = flow_jalr;
            flow.imm  = imm_i;
         end
         op_system: begin
            if (is_ebreak) begin
               flow.kind = flow_ebreak;  // ecall, csr ops fall through
            end
         end
         default: begin
            flow.kind = flow_seq;
         end
      endcase
   end

endmodule

// ==== flow_if.sv ====
`timescale 1ns/1ns

interface flow_if import rv_arch_pkg::*, rv_flow_pkg::*; ();

   flow_kind_t kind;
   cond_t      cond;
   reg_idx_t   rs1;
   reg_idx_t   rs2;
   imm_t       imm;

   modport decode (
      output kind,
      output cond,
      output rs1,
      output rs2,
      output imm
   );

   modport mux (
      input kind,
      input cond,
      input imm
   );

endinterface

// ==== next_pc_mux.sv ====
`timescale 1ns/1ns

module next_pc_mux import rv_arch_pkg::*, rv_flow_pkg::*; (
   flow_if.mux    flow,
   input  xlen_t  curr_pc,
   input  xlen_t  src1,
   input  xlen_t  src2,
   output xlen_t  next_pc,
   output logic   taken
);

   logic  cond_hit;
   xlen_t seq_pc;
   xlen_t rel_pc;
   xlen_t jalr_sum;

   assign seq_pc   = curr_pc + inst_bytes;
   assign rel_pc   = curr_pc + flow.imm;  // branch and jal target
   assign jalr_sum = src1 + flow.imm;

   always_comb begin
      case (flow.cond)
         cond_beq: begin
            cond_hit = (src1 == src2);
         end
         cond_bne: begin
            cond_hit = (src1 != src2);
         end
         cond_blt: begin
            cond_hit = ($signed(src1) < $signed(src2));
         end
         cond_bge: begin
            cond_hit = ($signed(src1) >= $signed(src2));
         end
         cond_bltu: begin
            cond_hit = (src1 < src2);
         end
         cond_bgeu: begin
            cond_hit = (src1 >= src2);
         end
         default: begin
            cond_hit = 1'b0;  // funct3 010/011 are not branches
         end
      endcase
   end

   always_comb begin
      next_pc = seq_pc;
      taken   = 1'b0;
      case (flow.kind)
         flow_branch: begin
            if (cond_hit) begin
               next_pc = rel_pc;
               taken   = 1'b1;
            end
         end
         flow_jal: begin
            next_pc = rel_pc;
            taken   = 1'b1;
         end
         flow_jalr: begin
            next_pc = {jalr_sum[63:1], 1'b0};  // lsb dropped per spec
            taken   = 1'b1;
         end
         flow_ebreak: begin
            next_pc = trap_vector;
            taken   = 1'b1;
         end
         flow_seq: begin
            next_pc = seq_pc;
         end
         default: begin
            next_pc = seq_pc;
         end
      endcase
   end

endmodule

// ==== pc_ctrl.sv ====
`timescale 1ns/1ns

module pc_ctrl import rv_arch_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  in_valid,
   output logic  in_ready,
   input  xlen_t next_pc,
   input  logic  taken,
   output xlen_t curr_pc,
   output logic  out_valid,
   input  logic  out_ready,
   output xlen_t out_pc,
   output logic  out_taken
);

   xlen_t pc_q;
   logic  out_valid_q;
   xlen_t out_pc_q;
   logic  out_taken_q;
   logic  accept;

   // slot is free, or it drains on this edge
   assign in_ready = !out_valid_q || out_ready;
   assign accept   = in_valid && in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q        <= reset_vector;
         out_valid_q <= 1'b0;
      end else begin
         if (accept) begin
            pc_q        <= next_pc;  // next inst sees the updated pc
            out_valid_q <= 1'b1;
         end else if (out_ready) begin
            out_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out_pc_q    <= next_pc;
         out_taken_q <= taken;
      end
   end

   assign curr_pc   = pc_q;
   assign out_valid = out_valid_q;
   assign out_pc    = out_pc_q;
   assign out_taken = out_taken_q;

endmodule

// ==== pc_unit_checker.sv ====
`timescale 1ns/1ns

module pc_unit_checker import rv_arch_pkg::*, rv_flow_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  in_ready,
   input  logic  out_valid,
   input  logic  out_ready,
   input  xlen_t out_pc,
   input  logic  out_taken,
   input  xlen_t exp_pc,
   input  logic  exp_taken,
   input  int    num_tests,
   output int    check_idx,
   output int    pass_count,
   output int    fail_count
);

   logic  first_edge;
   logic  held_valid;
   xlen_t held_pc;
   logic  held_taken;
   int    new_fails;
   logic  entry_ok;

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         check_idx  <= 0;
         pass_count <= 0;
         fail_count <= 0;
         first_edge <= 1'b1;
         held_valid <= 1'b0;
      end else begin
         new_fails = 0;
         if (first_edge) begin  // output slot must start empty
            if (out_valid !== 1'b0) begin
               $display("CHECK FAILED at %0t: out_valid got %b, expected 0", $time, out_valid);
               new_fails++;
            end
            if (in_ready !== 1'b1) begin
               $display("CHECK FAILED at %0t: in_ready got %b, expected 1", $time, in_ready);
               new_fails++;
            end
            first_edge <= 1'b0;
         end
         if (out_valid && !out_ready) begin  // full slot, no drain
            if (in_ready !== 1'b0) begin
               $display("CHECK FAILED at %0t: in_ready got %b, expected 0", $time, in_ready);
               new_fails++;
            end
         end
         if (held_valid) begin  // stalled on the last edge
            if (out_valid !== 1'b1) begin
               $display("CHECK FAILED at %0t: out_valid got %b, expected 1", $time, out_valid);
               new_fails++;
            end else begin
               if (out_pc !== held_pc) begin
                  $display("CHECK FAILED at %0t: out_pc got %h, expected %h",
                           $time, out_pc, held_pc);
                  new_fails++;
               end
               if (out_taken !== held_taken) begin
                  $display("CHECK FAILED at %0t: out_taken got %b, expected %b",
                           $time, out_taken, held_taken);
                  new_fails++;
               end
            end
         end
         if (out_valid && out_ready) begin
            if (check_idx >= num_tests) begin
               $display("extra output at %0t: pc %h arrived after the last test",
                        $time, out_pc);
               new_fails++;
            end else begin
               entry_ok = 1'b1;
               if (out_pc !== exp_pc) begin
                  $display("CHECK FAILED at %0t: out_pc got %h, expected %h",
                           $time, out_pc, exp_pc);
                  entry_ok = 1'b0;
               end
               if (out_taken !== exp_taken) begin
                  $display("CHECK FAILED at %0t: out_taken got %b, expected %b",
                           $time, out_taken, exp_taken);
                  entry_ok = 1'b0;
               end
               if (entry_ok) begin
                  $display("test %0d ok: out_pc %h out_taken %b", check_idx, out_pc, out_taken);
                  pass_count <= pass_count + 1;
               end else begin
                  $display("test %0d wrong", check_idx);
                  new_fails++;
               end
            end
            check_idx <= check_idx + 1;
         end
         held_valid <= out_valid && !out_ready;
         held_pc    <= out_pc;
         held_taken <= out_taken;
         fail_count <= fail_count + new_fails;
      end
   end

endmodule

// ==== pc_unit_top.sv ====
`timescale 1ns/1ns

module pc_unit_top import rv_arch_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  inst_t    inst,
   output logic     out_valid,
   input  logic     out_ready,
   output xlen_t    out_pc,
   output logic     out_taken,
   input  logic     wr_en,
   input  reg_idx_t wr_addr,
   input  xlen_t    wr_data
);

   xlen_t src1;
   xlen_t src2;
   xlen_t curr_pc;
   xlen_t next_pc;
   logic  taken;

   flow_if flow_bus ();

   flow_decode flow_decode_inst (
      .inst (inst),
      .flow (flow_bus.decode)
   );

   reg_file reg_file_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .rd_addr_a (flow_bus.rs1),
      .rd_addr_b (flow_bus.rs2),
      .rd_data_a (src1),
      .rd_data_b (src2)
   );

   next_pc_mux next_pc_mux_inst (
      .flow    (flow_bus.mux),
      .curr_pc (curr_pc),
      .src1    (src1),
      .src2    (src2),
      .next_pc (next_pc),
      .taken   (taken)
   );

   pc_ctrl pc_ctrl_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .next_pc   (next_pc),
      .taken     (taken),
      .curr_pc   (curr_pc),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_pc    (out_pc),
      .out_taken (out_taken)
   );

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns

module reg_file import rv_arch_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     wr_en,
   input  reg_idx_t wr_addr,
   input  xlen_t    wr_data,
   input  reg_idx_t rd_addr_a,
   input  reg_idx_t rd_addr_b,
   output xlen_t    rd_data_a,
   output xlen_t    rd_data_b
);

   xlen_t regs [reg_count];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_addr != '0)) begin  // x0 is hardwired
         regs[wr_addr] <= wr_data;
      end
   end

   // async read, no bypass of a same-cycle write
   assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
   assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// ==== rv_arch_pkg.sv ====
package rv_arch_pkg;

   // datapath widths
   localparam int xlen = 64;
   localparam int ilen = 32;
   localparam int reg_idx_w = 5;

   typedef logic [xlen-1:0]      xlen_t;     // register value or address
   typedef logic [ilen-1:0]      inst_t;     // raw instruction word
   typedef logic [reg_idx_w-1:0] reg_idx_t;  // x0..x31
   typedef logic [xlen-1:0]      imm_t;      // sign-extended immediate

   localparam int reg_count = 32;

   // reset pc and trap target share one address on this core
   localparam xlen_t reset_vector = 64'h0000_0000_8000_0000;
   localparam xlen_t trap_vector  = 64'h0000_0000_8000_0000;

   localparam xlen_t inst_bytes = 64'd4;  // sequential step

endpackage

// ==== rv_flow_pkg.sv ====
package rv_flow_pkg;

   typedef logic [2:0] flow_kind_t;
   typedef logic [2:0] cond_t;  // same bits as funct3

   localparam flow_kind_t flow_seq    = 3'd0;
   localparam flow_kind_t flow_branch = 3'd1;
   localparam flow_kind_t flow_jal    = 3'd2;
   localparam flow_kind_t flow_jalr   = 3'd3;
   localparam flow_kind_t flow_ebreak = 3'd4;

   // funct3 of the B-type group
   localparam cond_t cond_beq  = 3'b000;
   localparam cond_t cond_bne  = 3'b001;
   localparam cond_t cond_blt  = 3'b100;
   localparam cond_t cond_bge  = 3'b101;
   localparam cond_t cond_bltu = 3'b110;
   localparam cond_t cond_bgeu = 3'b111;

   // major opcodes, inst[6:0]
   localparam logic [6:0] op_branch = 7'b110_0011;
   localparam logic [6:0] op_jal    = 7'b110_1111;
   localparam logic [6:0] op_jalr   = 7'b110_0111;
   localparam logic [6:0] op_system = 7'b111_0011;

endpackage

// ==== tb_pc_unit.sv ====
`timescale 1ns/1ns

module tb_pc_unit import rv_arch_pkg::*, rv_flow_pkg::*;;

   localparam int max_tests = 40;
   localparam inst_t nop_word    = 32'h0000_0013;  // addi x0, x0, 0
   localparam inst_t add_word    = 32'h0020_81b3;  // add x3, x1, x2
   localparam inst_t ecall_word  = 32'h0000_0073;
   localparam inst_t ebreak_word = 32'h0010_0073;

   logic     clk = 1'b0;
   logic     rst_n;
   logic     in_valid;
   logic     in_ready;
   inst_t    inst;
   logic     out_valid;
   logic     out_ready;
   xlen_t    out_pc;
   logic     out_taken;
   logic     wr_en;
   reg_idx_t wr_addr;
   xlen_t    wr_data;

   inst_t inst_tbl      [max_tests];
   int    stall_tbl     [max_tests];  // cycles out_ready stays low
   xlen_t exp_pc_tbl    [max_tests];
   logic  exp_taken_tbl [max_tests];
   int    num_tests = 0;

   int          check_idx;
   int          pass_count;
   int          fail_count;
   xlen_t       exp_pc;
   logic        exp_taken;
   int          cycle_count = 0;
   int unsigned seed;
   int unsigned dummy;

   always #5 clk = ~clk;

   pc_unit_top pc_unit_top_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .inst      (inst),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_pc    (out_pc),
      .out_taken (out_taken),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data)
   );

   assign exp_pc    = exp_pc_tbl[check_idx];
   assign exp_taken = exp_taken_tbl[check_idx];

   pc_unit_checker pc_unit_checker_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_pc     (out_pc),
      .out_taken  (out_taken),
      .exp_pc     (exp_pc),
      .exp_taken  (exp_taken),
      .num_tests  (num_tests),
      .check_idx  (check_idx),
      .pass_count (pass_count),
      .fail_count (fail_count)
   );

   function automatic inst_t branch_word(input cond_t f3, input reg_idx_t rs1,
                                         input reg_idx_t rs2, input int off);
      logic [12:0] b;
      b = off[12:0];
      return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], op_branch};
   endfunction

   function automatic inst_t jal_word(input int off);
      logic [20:0] j;
      j = off[20:0];
      return {j[20], j[10:1], j[11], j[19:12], 5'd1, op_jal};
   endfunction

   function automatic inst_t jalr_word(input reg_idx_t rs1, input int off);
      return {off[11:0], rs1, 3'b000, 5'd1, op_jalr};
   endfunction

   task automatic add_entry(input inst_t word, input int stall, input xlen_t pc,
                            input logic taken);
      inst_tbl[num_tests]      = word;
      stall_tbl[num_tests]     = stall;
      exp_pc_tbl[num_tests]    = pc;
      exp_taken_tbl[num_tests] = taken;
      num_tests++;
   endtask

   // x1=x2=5, x3=x4=-3, x5 big positive, x6 odd address, x7 most negative
   task automatic load_table();
      add_entry(nop_word, 0, 64'h8000_0004, 1'b0);
      add_entry(branch_word(cond_beq, 5'd1, 5'd2, 16), 0, 64'h8000_0014, 1'b1);
      add_entry(branch_word(cond_beq, 5'd1, 5'd3, 16), 0, 64'h8000_0018, 1'b0);
      add_entry(branch_word(cond_bne, 5'd1, 5'd3, 32), 0, 64'h8000_0038, 1'b1);
      add_entry(branch_word(cond_bne, 5'd3, 5'd4, 32), 0, 64'h8000_003c, 1'b0);
      add_entry(branch_word(cond_blt, 5'd3, 5'd1, 8), 3, 64'h8000_0044, 1'b1);
      add_entry(branch_word(cond_blt, 5'd1, 5'd3, 8), 0, 64'h8000_0048, 1'b0);
      add_entry(branch_word(cond_blt, 5'd7, 5'd5, -8), 0, 64'h8000_0040, 1'b1);
      add_entry(branch_word(cond_bge, 5'd1, 5'd2, 12), 0, 64'h8000_004c, 1'b1);
      add_entry(branch_word(cond_bge, 5'd3, 5'd1, 12), 2, 64'h8000_0050, 1'b0);
      add_entry(branch_word(cond_bltu, 5'd1, 5'd3, 20), 1, 64'h8000_0064, 1'b1);
      add_entry(branch_word(cond_bltu, 5'd3, 5'd1, 20), 0, 64'h8000_0068, 1'b0);
      add_entry(branch_word(cond_bgeu, 5'd3, 5'd1, -16), 0, 64'h8000_0058, 1'b1);
      add_entry(branch_word(cond_bgeu, 5'd5, 5'd7, 4), 0, 64'h8000_005c, 1'b0);
      add_entry(branch_word(cond_bge, 5'd5, 5'd7, 24), 0, 64'h8000_0074, 1'b1);
      add_entry(branch_word(cond_bltu, 5'd7, 5'd5, 8), 0, 64'h8000_0078, 1'b0);
      add_entry(branch_word(3'b010, 5'd1, 5'd2, 8), 0, 64'h8000_007c, 1'b0);  // no such branch
      add_entry(jal_word(256), 4, 64'h8000_017c, 1'b1);
      add_entry(jal_word(-128), 0, 64'h8000_00fc, 1'b1);
      add_entry(nop_word, 0, 64'h8000_0100, 1'b0);
      add_entry(jalr_word(5'd6, 0), 0, 64'h8000_1000, 1'b1);  // odd sum
      add_entry(jalr_word(5'd1, 32), 0, 64'h0000_0024, 1'b1);
      add_entry(jalr_word(5'd3, 19), 0, 64'h0000_0010, 1'b1);
      add_entry(ebreak_word, 2, 64'h8000_0000, 1'b1);
      add_entry(nop_word, 0, 64'h8000_0004, 1'b0);
      add_entry(jalr_word(5'd0, 2047), 0, 64'h0000_07fe, 1'b1);  // x0 was written
      add_entry(jalr_word(5'd0, -257), 0, 64'hffff_ffff_ffff_fefe, 1'b1);
      add_entry(ecall_word, 0, 64'hffff_ffff_ffff_ff02, 1'b0);
      add_entry(add_word, 3, 64'hffff_ffff_ffff_ff06, 1'b0);
      add_entry(branch_word(cond_beq, 5'd0, 5'd0, -4), 0, 64'hffff_ffff_ffff_ff02, 1'b1);
      add_entry(ebreak_word, 0, 64'h8000_0000, 1'b1);
      add_entry(nop_word, 0, 64'h8000_0004, 1'b0);
   endtask

   task automatic write_reg(input reg_idx_t addr, input xlen_t data);
      wr_en   <= 1'b1;
      wr_addr <= addr;
      wr_data <= data;
      @(posedge clk);
      wr_en   <= 1'b0;
   endtask

   task automatic preload_regs();
      write_reg(5'd1, 64'd5);
      write_reg(5'd2, 64'd5);
      write_reg(5'd3, 64'hffff_ffff_ffff_fffd);
      write_reg(5'd4, 64'hffff_ffff_ffff_fffd);
      write_reg(5'd5, 64'h7fff_ffff_ffff_fff0);
      write_reg(5'd6, 64'h0000_0000_8000_1001);
      write_reg(5'd7, 64'h8000_0000_0000_0000);
      write_reg(5'd0, 64'h0123_4567_89ab_cdef);  // must be dropped
   endtask

   task automatic drive_inputs();
      int idle;
      int k;
      for (k = 0; k < num_tests; k++) begin
         idle = $urandom % 3;
         if (idle != 0) begin
            in_valid <= 1'b0;
            repeat (idle) @(posedge clk);
         end
         in_valid <= 1'b1;
         inst     <= inst_tbl[k];
         do @(posedge clk); while (!in_ready);  // held until accepted
      end
      in_valid <= 1'b0;
   endtask

   task automatic drain_outputs();
      int held;
      int j;
      for (j = 0; j < num_tests; j++) begin
         if (stall_tbl[j] != 0) begin
            out_ready <= 1'b0;
            held = 0;
            while (held < stall_tbl[j]) begin
               @(posedge clk);
               if (out_valid) begin
                  held++;
               end
            end
            out_ready <= 1'b1;
         end
         do @(posedge clk); while (!(out_valid && out_ready));
      end
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= 20 * num_tests + 100) begin
         $display("timeout: outputs stopped arriving, %0d of %0d results seen after %0d cycles",
                  check_idx, num_tests, cycle_count);
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      seed  = 32'h8602299f;
      dummy = $urandom(seed);
      load_table();
      rst_n     <= 1'b0;
      in_valid  <= 1'b0;
      inst      <= nop_word;
      out_ready <= 1'b1;
      wr_en     <= 1'b0;
      wr_addr   <= '0;
      wr_data   <= '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      preload_regs();
      fork
         drive_inputs();
         drain_outputs();
      join
      repeat (4) @(posedge clk);  // catch stray extra outputs
      $display("%0d passed, %0d failed, %0d of %0d outputs seen",
               pass_count, fail_count, check_idx, num_tests);
      if (fail_count == 0 && check_idx == num_tests) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
